// ==== files.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_decoder.sv
verilog/cpu_register_file.sv
verilog/cpu_alu.sv
verilog/cpu_hazard_unit.sv
verilog/cpu.sv
sim/cpu_props.sv
sim/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim 2>&1 | tee sim.log
if grep -qx "No errors" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== sim/cpu_props.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_props import cpu_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        data_we,
  input word_t       instr_addr,
  input logic        stall_d,
  input logic        flush_e,
  input logic        reg_write_e,
  input result_src_t result_src_e,
  input logic        jump_e,
  input logic        branch_e,
  input logic        branch_ne_e,
  input word_t       src_a_e,
  input word_t       write_data_e,
  input reg_addr_t   rd_e,
  input reg_addr_t   rs1_d,
  input reg_addr_t   rs2_d
);

  logic load_in_e;
  logic load_use;
  logic taken_e;

  // Live LW in execute writes its register from memory data
  assign load_in_e = reg_write_e && result_src_e == RES_DATA;
  assign load_use  = load_in_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

  // Branch outcome straight from the forwarded operands
  assign taken_e = jump_e || (branch_e && ((src_a_e == write_data_e) != branch_ne_e));

  // Store port stays quiet while reset is held
  no_store_in_reset: assert property (@(posedge clk) !rst_n |=> !data_we)
    else $error("data_we high during reset");

  flush_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
    flush_e |-> (taken_e || load_use))
    else $error("flush_e set with no taken branch or jump and no load-use hazard");

  stall_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
    stall_d |-> load_use)
    else $error("stall_d set with no load-use hazard");

  first_fetch: assert property (@(posedge clk) $rose(rst_n) |-> instr_addr == `CPU_RESET_PC)
    else $error("first fetch address after reset is wrong");

endmodule

bind cpu cpu_props props (
  .clk          (clk),
  .rst_n        (rst_n),
  .data_we      (data_we),
  .instr_addr   (instr_addr),
  .stall_d      (stall_d),
  .flush_e      (flush_e),
  .reg_write_e  (reg_write_e),
  .result_src_e (result_src_e),
  .jump_e       (jump_e),
  .branch_e     (branch_e),
  .branch_ne_e  (branch_ne_e),
  .src_a_e      (src_a_e),
  .write_data_e (write_data_e),
  .rd_e         (rd_e),
  .rs1_d        (rs1_d),
  .rs2_d        (rs2_d)
);

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb import cpu_pkg::*; ();

  // BEQ x0, x0, 0 spins in place and ends the program
  localparam word_t HALT_INSTR = 32'h0000_0063;

  logic  clk;
  logic  rst_n;
  word_t instr_addr, instr_data;
  word_t data_addr, data_wdata, data_rdata;
  logic  data_we;

  word_t rom [256];
  word_t ram [256];
  word_t exp_addr [$];
  word_t exp_data [$];
  int    prog_len;
  int    exp_count;
  int    store_idx = 0;
  int    watchdog_cycles;

  cpu uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we),
    .data_rdata (data_rdata)
  );

  always #20 clk = ~clk;

  function automatic word_t fill_word(int idx);
    return (word_t'(idx) * 32'h0103_0507) ^ 32'ha5c3_0000;
  endfunction

  // Both memories answer in the same cycle
  assign instr_data = rom[instr_addr[9:2]];
  assign data_rdata = ram[data_addr[9:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        ram[i] <= fill_word(i);
      end
    end else if (data_we) begin
      ram[data_addr[9:2]] <= data_wdata;
    end
  end

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(logic [19:0] hi, reg_addr_t rd);
    return {hi, rd, OPC_LUI};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic reg_addr_t pick_dest();
    return reg_addr_t'($urandom_range(1, 7));
  endfunction

  function automatic reg_addr_t pick_src();
    return reg_addr_t'($urandom_range(0, 7));
  endfunction

  function automatic logic [11:0] rand_imm();
    return 12'($urandom);
  endfunction

  // Word aligned, inside the 256-word RAM
  function automatic logic [11:0] rand_offset();
    return 12'($urandom_range(0, 255) * 4);
  endfunction

  // 0 ADD, 1 SUB, 2 AND, 3 OR, 4 XOR, 5 SLT
  function automatic logic [2:0] funct3_of(int k);
    case (k)
      0, 1:    return 3'b000;
      2:       return 3'b111;
      3:       return 3'b110;
      4:       return 3'b100;
      default: return 3'b010;
    endcase
  endfunction

  function automatic word_t alu_instr(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    int k;
    k = $urandom_range(0, 5);
    return enc_r((k == 1) ? 7'h20 : 7'h00, rs2, rs1, funct3_of(k), rd);
  endfunction

  function automatic word_t alu_imm_instr(reg_addr_t rd, reg_addr_t rs1);
    int k;
    k = $urandom_range(0, 5);
    if (k == 1)
      k = 0;
    return enc_i(rand_imm(), rs1, funct3_of(k), rd, OPC_OP_IMM);
  endfunction

  function automatic word_t store_instr(reg_addr_t rs);
    return enc_s(rand_offset(), rs, 5'd0);
  endfunction

  function automatic word_t load_instr(reg_addr_t rd);
    return enc_i(rand_offset(), 5'd0, 3'b010, rd, OPC_LOAD);
  endfunction

  task automatic emit(word_t w);
    rom[prog_len] = w;
    prog_len = prog_len + 1;
  endtask

  task automatic gen_program();
    reg_addr_t d, e, s, u;
    int        kind;
    for (int i = 0; i < 256; i++) begin
      rom[i] = `CPU_NOP;
    end
    prog_len = 0;
    // Full words in x1..x7 before anything reads them
    for (int r = 1; r < 8; r++) begin
      d = reg_addr_t'(r);
      emit(enc_u(20'($urandom), d));
      emit(enc_i(rand_imm(), d, 3'b000, d, OPC_OP_IMM));
      emit(store_instr(d));
    end
    for (int blk = 0; blk < 24; blk++) begin
      kind = $urandom_range(0, 5);
      d = pick_dest();
      e = pick_dest();
      s = pick_dest();
      u = ($urandom_range(0, 1) == 1) ? s : pick_src();
      case (kind)
        0: begin
          emit(alu_instr(d, pick_src(), pick_src()));
          emit(alu_instr(e, d, pick_src()));
          emit(alu_instr(s, d, e));
          emit(store_instr(s));
        end
        1: begin
          emit(alu_imm_instr(d, pick_src()));
          emit(alu_imm_instr(e, d));
          emit(store_instr(e));
          emit(store_instr(d));
        end
        2: begin
          emit(load_instr(d));
          emit(enc_r(7'h00, pick_src(), d, 3'b000, e));
          emit(store_instr(e));
          emit(load_instr(s));
          emit(store_instr(s));
        end
        3: begin
          // Taken branch skips the ADDI and the first store
          emit(enc_b(13'd12, u, s, ($urandom_range(0, 1) == 1) ? 3'b001 : 3'b000));
          emit(alu_imm_instr(d, d));
          emit(store_instr(d));
          emit(store_instr(d));
        end
        4: begin
          emit(enc_j(21'd12, d));
          emit(alu_imm_instr(e, e));
          emit(store_instr(e));
          emit(store_instr(d));
        end
        default: begin
          emit(alu_imm_instr(5'd0, pick_src()));
          emit(alu_instr(5'd0, pick_src(), pick_src()));
          emit(store_instr(5'd0));
        end
      endcase
    end
    emit(HALT_INSTR);
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return '0;
    endcase
  endfunction

  function automatic word_t imm_i(word_t ins);
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  function automatic word_t imm_s(word_t ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
  endfunction

  function automatic word_t imm_b(word_t ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  endfunction

  function automatic word_t imm_j(word_t ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  endfunction

  // Instruction-level model, one instruction per step
  function automatic int run_reference();
    word_t regs [32];
    word_t mem [256];
    word_t pc, ins, a, b, res, next_pc, addr;
    logic  wr;
    int    steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
    end
    pc = `CPU_RESET_PC;
    steps = 0;
    while (rom[pc[9:2]] != HALT_INSTR && steps < 1024) begin
      ins = rom[pc[9:2]];
      a = regs[ins[19:15]];
      b = regs[ins[24:20]];
      next_pc = pc + 32'd4;
      wr = 1'b0;
      res = '0;
      case (opcode_t'(ins[6:0]))
        OPC_OP: begin
          res = alu_ref(ins[14:12], ins[30], a, b);
          wr = 1'b1;
        end
        OPC_OP_IMM: begin
          res = alu_ref(ins[14:12], 1'b0, a, imm_i(ins));
          wr = 1'b1;
        end
        OPC_LUI: begin
          res = {ins[31:12], 12'h000};
          wr = 1'b1;
        end
        OPC_LOAD: begin
          addr = a + imm_i(ins);
          res = mem[addr[9:2]];
          wr = 1'b1;
        end
        OPC_STORE: begin
          addr = a + imm_s(ins);
          mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        OPC_BRANCH: begin
          if ((a == b) != ins[12])
            next_pc = pc + imm_b(ins);
        end
        OPC_JAL: begin
          res = pc + 32'd4;
          wr = 1'b1;
          next_pc = pc + imm_j(ins);
        end
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0)
        regs[ins[11:7]] = res;
      pc = next_pc;
      steps++;
    end
    return exp_addr.size();
  endfunction

  task automatic fail_now();
    $display("Errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(string name, word_t got, word_t expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
      fail_now();
    end
  endtask

  task automatic check_count(string name, int got, int expected);
    if (got != expected) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, expected);
      fail_now();
    end
  endtask

  // Store port compare, sampled away from the active edge
  always @(negedge clk) begin
    if (rst_n && data_we) begin
      store_idx = store_idx + 1;
      if (store_idx > exp_count) begin
        check_count("store count", store_idx, exp_count);
      end else begin
        check_word("data_addr", data_addr, exp_addr[store_idx - 1]);
        check_word("data_wdata", data_wdata, exp_data[store_idx - 1]);
      end
    end
  end

  initial begin
    wait (rst_n === 1'b1);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the program did not finish within %0d cycles", watchdog_cycles);
    fail_now();
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    void'($urandom(32'h6c3f75a9));
    gen_program();
    exp_count = run_reference();
    watchdog_cycles = 3 * prog_len + 40;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_word("instr_addr", instr_addr, `CPU_RESET_PC);
    wait (store_idx == exp_count);
    // Late stores from skipped code would show up here
    repeat (20) @(posedge clk);
    if (store_idx == exp_count) begin
      $display("No errors");
      $finish;
    end else begin
      check_count("store count", store_idx, exp_count);
    end
  end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t instr_addr,
  input  word_t instr_data,
  output word_t data_addr,
  output word_t data_wdata,
  output logic  data_we,
  input  word_t data_rdata
);

  fwd_sel_t fwd_a, fwd_b;
  logic     stall_f, stall_d, flush_d, flush_e;
  logic     redirect_e;
  word_t    pc_target_e;
  word_t    result_pre_m;
  word_t    result_w;

  // Fetch, always predicting fall-through
  word_t pc_f;
  word_t pc_plus_4_f;

  assign pc_plus_4_f = pc_f + word_t'(4);
  assign instr_addr  = pc_f;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_f <= `CPU_RESET_PC;
    end else if (redirect_e) begin
      pc_f <= pc_target_e;
    end else if (!stall_f) begin
      pc_f <= pc_plus_4_f;
    end
  end

  // Decode
  word_t instr_d, pc_d, pc_plus_4_d;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_d) begin
      instr_d <= `CPU_NOP;
    end else if (!stall_d) begin
      instr_d <= instr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d        <= pc_f;
      pc_plus_4_d <= pc_plus_4_f;
    end
  end

  reg_addr_t   rs1_d, rs2_d, rd_d;
  logic        reg_write_d, mem_write_d, is_load_d, branch_d, branch_ne_d, jump_d;
  alu_op_t     alu_op_d;
  logic        alu_src_imm_d;
  result_src_t result_src_d;
  word_t       imm_d, rd1_d, rd2_d;

  assign rs1_d = instr_d[19:15];
  assign rs2_d = instr_d[24:20];
  assign rd_d  = instr_d[11:7];

  cpu_decoder decoder (
    .instr       (instr_d),
    .reg_write   (reg_write_d),
    .mem_write   (mem_write_d),
    .is_load     (is_load_d),
    .branch      (branch_d),
    .branch_ne   (branch_ne_d),
    .jump        (jump_d),
    .alu_op      (alu_op_d),
    .alu_src_imm (alu_src_imm_d),
    .result_src  (result_src_d),
    .imm         (imm_d)
  );

  logic      reg_write_w;
  reg_addr_t rd_w;

  cpu_register_file reg_file (
    .clk (clk),
    .ra1 (rs1_d),
    .ra2 (rs2_d),
    .rd1 (rd1_d),
    .rd2 (rd2_d),
    .wa  (rd_w),
    .wd  (result_w),
    .we  (reg_write_w)
  );

  // Execute
  logic        reg_write_e, mem_write_e, is_load_e, branch_e, jump_e;
  logic        branch_ne_e, alu_src_imm_e;
  alu_op_t     alu_op_e;
  result_src_t result_src_e;
  word_t       rd1_e, rd2_e, imm_e, pc_e, pc_plus_4_e;
  reg_addr_t   rs1_e, rs2_e, rd_e;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_e) begin
      reg_write_e <= 1'b0;
      mem_write_e <= 1'b0;
      is_load_e   <= 1'b0;
      branch_e    <= 1'b0;
      jump_e      <= 1'b0;
    end else begin
      reg_write_e <= reg_write_d;
      mem_write_e <= mem_write_d;
      is_load_e   <= is_load_d;
      branch_e    <= branch_d;
      jump_e      <= jump_d;
    end
  end

  always_ff @(posedge clk) begin
    branch_ne_e   <= branch_ne_d;
    alu_src_imm_e <= alu_src_imm_d;
    alu_op_e      <= alu_op_d;
    result_src_e  <= result_src_d;
    rd1_e         <= rd1_d;
    rd2_e         <= rd2_d;
    imm_e         <= imm_d;
    pc_e          <= pc_d;
    pc_plus_4_e   <= pc_plus_4_d;
    rs1_e         <= rs1_d;
    rs2_e         <= rs2_d;
    rd_e          <= rd_d;
  end

  word_t src_a_e, write_data_e, src_b_e, alu_result_e;
  logic  alu_zero_e;

  function automatic word_t operand(fwd_sel_t sel, word_t rf_val);
    case (sel)
      FWD_MEMORY:    return result_pre_m;
      FWD_WRITEBACK: return result_w;
      default:       return rf_val;
    endcase
  endfunction

  always_comb begin
    src_a_e      = operand(fwd_a, rd1_e);
    write_data_e = operand(fwd_b, rd2_e);
  end

  assign src_b_e = alu_src_imm_e ? imm_e : write_data_e;

  cpu_alu alu (
    .a      (src_a_e),
    .b      (src_b_e),
    .op     (alu_op_e),
    .result (alu_result_e),
    .zero   (alu_zero_e)
  );

  assign pc_target_e = pc_e + imm_e;
  assign redirect_e  = jump_e | (branch_e & (alu_zero_e ^ branch_ne_e));

  // Memory
  logic        reg_write_m, mem_write_m;
  result_src_t result_src_m;
  word_t       alu_result_m, write_data_m, pc_plus_4_m;
  reg_addr_t   rd_m;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_m <= 1'b0;
      mem_write_m <= 1'b0;
    end else begin
      reg_write_m <= reg_write_e;
      mem_write_m <= mem_write_e;
    end
  end

  always_ff @(posedge clk) begin
    result_src_m <= result_src_e;
    alu_result_m <= alu_result_e;
    write_data_m <= write_data_e;
    pc_plus_4_m  <= pc_plus_4_e;
    rd_m         <= rd_e;
  end

  assign data_addr  = alu_result_m;
  assign data_wdata = write_data_m;
  assign data_we    = mem_write_m;

  // Load data only arrives in writeback, so it is never forwarded from here
  assign result_pre_m = (result_src_m == RES_PC_PLUS_4) ? pc_plus_4_m : alu_result_m;

  // Writeback
  result_src_t result_src_w;
  word_t       result_pre_w, read_data_w;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_w <= 1'b0;
    end else begin
      reg_write_w <= reg_write_m;
    end
  end

  always_ff @(posedge clk) begin
    result_src_w <= result_src_m;
    result_pre_w <= result_pre_m;
    read_data_w  <= data_rdata;
    rd_w         <= rd_m;
  end

  assign result_w = (result_src_w == RES_DATA) ? read_data_w : result_pre_w;

  cpu_hazard_unit hazard_unit (
    .rs1_d       (rs1_d),
    .rs2_d       (rs2_d),
    .rs1_e       (rs1_e),
    .rs2_e       (rs2_e),
    .rd_e        (rd_e),
    .rd_m        (rd_m),
    .rd_w        (rd_w),
    .is_load_e   (is_load_e),
    .reg_write_m (reg_write_m),
    .reg_write_w (reg_write_w),
    .redirect_e  (redirect_e),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .stall_f     (stall_f),
    .stall_d     (stall_d),
    .flush_d     (flush_d),
    .flush_e     (flush_e)
  );

endmodule

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result,
  output logic    zero
);

  logic lt;

  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLT:    result = word_t'(lt);
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Branch compare uses SUB, so equal operands give zero
  assign zero = (result == '0);

endmodule

// ==== verilog/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data and address width
`define CPU_XLEN 32

// Architectural register count
`define CPU_NREGS 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define CPU_NOP 32'h0000_0013

`endif

// ==== verilog/cpu_decoder.sv ====
`timescale 1ns/1ps

module cpu_decoder import cpu_pkg::*; (
  input  word_t       instr,
  output logic        reg_write,
  output logic        mem_write,
  output logic        is_load,
  output logic        branch,
  output logic        branch_ne,
  output logic        jump,
  output alu_op_t     alu_op,
  output logic        alu_src_imm,
  output result_src_t result_src,
  output word_t       imm
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       arith_ok;
  alu_op_t    arith_op;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  // Shared by OP and OP-IMM; SUB only exists in register form
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b010:  arith_op = ALU_SLT;
      3'b100:  arith_op = ALU_XOR;
      3'b110:  arith_op = ALU_OR;
      3'b111:  arith_op = ALU_AND;
      default: begin
        arith_op = ALU_ADD;
        arith_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    is_load     = 1'b0;
    branch      = 1'b0;
    branch_ne   = funct3[0];
    jump        = 1'b0;
    alu_op      = arith_op;
    alu_src_imm = 1'b1;
    result_src  = RES_ALU;
    imm         = {{20{instr[31]}}, instr[31:20]};
    case (opcode)
      OPC_OP: begin
        reg_write   = arith_ok;
        alu_src_imm = 1'b0;
      end
      OPC_OP_IMM: reg_write = arith_ok;
      OPC_LUI: begin
        reg_write = 1'b1;
        alu_op    = ALU_PASS_B;
        imm       = {instr[31:12], 12'b0};
      end
      OPC_LOAD: begin
        reg_write  = (funct3 == 3'b010);
        is_load    = (funct3 == 3'b010);
        alu_op     = ALU_ADD;
        result_src = RES_DATA;
      end
      OPC_STORE: begin
        mem_write = (funct3 == 3'b010);
        alu_op    = ALU_ADD;
        imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OPC_BRANCH: begin
        // BEQ and BNE only
        branch      = (funct3[2:1] == 2'b00);
        alu_op      = ALU_SUB;
        alu_src_imm = 1'b0;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      OPC_JAL: begin
        reg_write  = 1'b1;
        jump       = 1'b1;
        result_src = RES_PC_PLUS_4;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: alu_op = ALU_ADD;
    endcase
  end

endmodule

// ==== verilog/cpu_hazard_unit.sv ====
`timescale 1ns/1ps

module cpu_hazard_unit import cpu_pkg::*; (
  input  reg_addr_t rs1_d,
  input  reg_addr_t rs2_d,
  input  reg_addr_t rs1_e,
  input  reg_addr_t rs2_e,
  input  reg_addr_t rd_e,
  input  reg_addr_t rd_m,
  input  reg_addr_t rd_w,
  input  logic      is_load_e,
  input  logic      reg_write_m,
  input  logic      reg_write_w,
  input  logic      redirect_e,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b,
  output logic      stall_f,
  output logic      stall_d,
  output logic      flush_d,
  output logic      flush_e
);

  logic load_use;

  // Younger result wins
  function automatic fwd_sel_t fwd_select(reg_addr_t rs);
    if (rs != '0 && reg_write_m && rd_m == rs)
      return FWD_MEMORY;
    if (rs != '0 && reg_write_w && rd_w == rs)
      return FWD_WRITEBACK;
    return FWD_NONE;
  endfunction

  always_comb begin
    fwd_a = fwd_select(rs1_e);
    fwd_b = fwd_select(rs2_e);
  end

  assign load_use = is_load_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

  // Hold fetch and decode, bubble into execute
  assign stall_f = load_use;
  assign stall_d = load_use;

  assign flush_d = redirect_e;
  assign flush_e = redirect_e | load_use;

endmodule

// ==== verilog/cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEMORY,
    FWD_WRITEBACK
  } fwd_sel_t;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_DATA,
    RES_PC_PLUS_4
  } result_src_t;

endpackage

// ==== verilog/cpu_register_file.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_register_file import cpu_pkg::*; (
  input  logic      clk,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  output word_t     rd1,
  output word_t     rd2,
  input  reg_addr_t wa,
  input  word_t     wd,
  input  logic      we
);

  word_t regs [`CPU_NREGS];

  // Same-cycle write is visible to the reader
  function automatic word_t read_reg(reg_addr_t ra);
    if (ra == '0)
      return '0;
    if (we && wa == ra)
      return wd;
    return regs[ra];
  endfunction

  always_comb begin
    rd1 = read_reg(ra1);
    rd2 = read_reg(ra2);
  end

  always_ff @(posedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

endmodule
